// ==== hw/cnn_pkg.sv ====
package cnn_pkg;

  // ==========================================================================
  // word types
  // ==========================================================================

  // pixels and results
  typedef logic signed [15:0] data_t;

  // weights and biases
  typedef logic signed [7:0] weight_t;

  // wide enough for a full tap sum plus bias
  typedef logic signed [31:0] acc_t;

  // channel counts, image side, kernel side, padding
  typedef logic [7:0] len_t;

  // ==========================================================================
  // controller states
  // ==========================================================================

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_load  = 2'd1,
    st_pixel = 2'd2,
    st_drain = 2'd3
  } core_state_t;

endpackage

// ==== hw/cnn_mem.sv ====
module cnn_mem #(
  parameter type word_t = logic [7:0],
  parameter int depth = 256,
  localparam int aw = $clog2(depth)
) (
  input                 clk,
  input                 we,
  input        [aw-1:0] waddr,
  input  word_t         wdata,
  input        [aw-1:0] raddr,
  output word_t         rdata
);

  word_t mem [depth];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== hw/cnn_ctrl_core.sv ====
module cnn_ctrl_core #(
  parameter int n_core = 2,
  parameter int img_depth = 1024,
  parameter int net_depth = 256,
  localparam int iw = $clog2(img_depth),
  localparam int nw = $clog2(net_depth),
  localparam int sw = (n_core > 1) ? $clog2(n_core) : 1
) (
  input                             clk,
  input                             xrst,
  input                             req,
  output logic                      busy,
  output logic                      done,
  output cnn_pkg::core_state_t      core_state,
  input              [iw-1:0]       in_offset,
  input              [iw-1:0]       out_offset,
  input  cnn_pkg::len_t             total_in,
  input  cnn_pkg::len_t             total_out,
  input  cnn_pkg::len_t             img_size,
  input  cnn_pkg::len_t             conv_size,
  input  cnn_pkg::len_t             conv_pad,
  input                             bias_en,
  input                             relu_en,
  input                             img_we,
  input              [iw-1:0]       img_addr,
  input  cnn_pkg::data_t            img_wdata,
  input                             net_we,
  input              [sw-1:0]       net_sel,
  output logic                      pix_start,
  output cnn_pkg::len_t             pix_x,
  output cnn_pkg::len_t             pix_y,
  output cnn_pkg::len_t             fea_size,
  output logic       [nw-1:0]       net_base,
  output logic       [iw-1:0]       in_base,
  output logic       [iw-1:0]       out_base,
  output cnn_pkg::len_t             pix_ch0,
  input              [iw-1:0]       fetch_raddr,
  input                             ser_we,
  input              [iw-1:0]       ser_addr,
  input  cnn_pkg::data_t            ser_wdata,
  input                             ser_done,
  output logic                      mem_we,
  output logic       [iw-1:0]       mem_waddr,
  output cnn_pkg::data_t            mem_wdata,
  output logic       [iw-1:0]       mem_raddr,
  output logic       [n_core-1:0]   net_core_we,
  output logic                      bias_en_q,
  output logic                      relu_en_q
);

  cnn_pkg::core_state_t state;
  cnn_pkg::len_t        total_in_q;
  cnn_pkg::len_t        total_out_q;
  cnn_pkg::len_t        img_size_q;
  cnn_pkg::len_t        conv_size_q;
  cnn_pkg::len_t        conv_pad_q;
  logic [nw-1:0]        blk_len;
  logic                 pix_last;
  logic                 grp_last;

  assign core_state = state;
  assign busy       = state != cnn_pkg::st_idle;
  assign done       = state == cnn_pkg::st_drain;

  assign pix_last = pix_x == fea_size - 1 && pix_y == fea_size - 1;
  assign grp_last = int'(pix_ch0) + n_core >= int'(total_out_q);

  // ==========================================================================
  // main FSM
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= cnn_pkg::st_idle;
      pix_start <= 1'b0;
    end else begin
      pix_start <= 1'b0;
      case (state)
        cnn_pkg::st_idle: begin
          if (req) begin
            state <= cnn_pkg::st_load;
          end
        end
        cnn_pkg::st_load: begin
          state     <= cnn_pkg::st_pixel;
          pix_start <= 1'b1;
        end
        cnn_pkg::st_pixel: begin
          // next pixel only once the serializer is through
          if (ser_done) begin
            if (pix_last && grp_last) begin
              state <= cnn_pkg::st_drain;
            end else begin
              pix_start <= 1'b1;
            end
          end
        end
        default: begin
          state <= cnn_pkg::st_idle;
        end
      endcase
    end
  end

  // settings taken on the accepted req, derived sizes one cycle later
  always_ff @(posedge clk) begin
    if (state == cnn_pkg::st_idle && req) begin
      in_base     <= in_offset;
      out_base    <= out_offset;
      total_in_q  <= total_in;
      total_out_q <= total_out;
      img_size_q  <= img_size;
      conv_size_q <= conv_size;
      conv_pad_q  <= conv_pad;
      bias_en_q   <= bias_en;
      relu_en_q   <= relu_en;
    end
    if (state == cnn_pkg::st_load) begin
      fea_size <= img_size_q + (conv_pad_q << 1) - conv_size_q + 8'd1;
      // taps of all input channels plus the bias word
      blk_len  <= nw'(int'(total_in_q) * int'(conv_size_q) * int'(conv_size_q) + 1);
    end
  end

  // ==========================================================================
  // pixel and group counters
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      pix_x    <= '0;
      pix_y    <= '0;
      pix_ch0  <= '0;
      net_base <= '0;
    end else if (state == cnn_pkg::st_load) begin
      pix_x    <= '0;
      pix_y    <= '0;
      pix_ch0  <= '0;
      net_base <= '0;
    end else if (state == cnn_pkg::st_pixel && ser_done) begin
      if (pix_x == fea_size - 1) begin
        pix_x <= '0;
        if (pix_y == fea_size - 1) begin
          // wrap to the next group of output channels
          pix_y    <= '0;
          pix_ch0  <= pix_ch0 + cnn_pkg::len_t'(n_core);
          net_base <= net_base + blk_len;
        end else begin
          pix_y <= pix_y + 8'd1;
        end
      end else begin
        pix_x <= pix_x + 8'd1;
      end
    end
  end

  // ==========================================================================
  // memory port arbitration
  // ==========================================================================

  // host owns the image memory while idle
  assign mem_we    = busy ? ser_we : img_we;
  assign mem_waddr = busy ? ser_addr : img_addr;
  assign mem_wdata = busy ? ser_wdata : img_wdata;
  assign mem_raddr = busy ? fetch_raddr : img_addr;

  // weight write enable per core
  for (genvar i = 0; i < n_core; i++) begin : g_net_we
    assign net_core_we[i] = net_we && net_sel == sw'(i);
  end

endmodule

// ==== hw/cnn_tap_fetch.sv ====
module cnn_tap_fetch #(
  parameter int img_depth = 1024,
  parameter int net_depth = 256,
  localparam int iw = $clog2(img_depth),
  localparam int nw = $clog2(net_depth)
) (
  input                       clk,
  input                       xrst,
  input                       pix_start,
  input  cnn_pkg::len_t       pix_x,
  input  cnn_pkg::len_t       pix_y,
  input  cnn_pkg::len_t       total_in,
  input  cnn_pkg::len_t       img_size,
  input  cnn_pkg::len_t       conv_size,
  input  cnn_pkg::len_t       conv_pad,
  input              [iw-1:0] in_base,
  input              [nw-1:0] net_base,
  output logic       [iw-1:0] img_raddr,
  output logic       [nw-1:0] net_raddr,
  output logic                tap_valid,
  output logic                tap_pad,
  output logic                tap_first,
  output logic                tap_bias
);

  logic          active;
  logic          bias_ph;
  cnn_pkg::len_t ic;
  cnn_pkg::len_t ky;
  cnn_pkg::len_t kx;
  logic [nw-1:0] woff;
  int            iy;
  int            ix;
  logic          pad_now;

  // channel, row, column walk, then one bias beat
  always_ff @(posedge clk) begin
    if (!xrst) begin
      active  <= 1'b0;
      bias_ph <= 1'b0;
      ic      <= '0;
      ky      <= '0;
      kx      <= '0;
      woff    <= '0;
    end else if (pix_start) begin
      active  <= 1'b1;
      bias_ph <= 1'b0;
      ic      <= '0;
      ky      <= '0;
      kx      <= '0;
      woff    <= '0;
    end else if (active) begin
      woff <= woff + 1'b1;
      if (bias_ph) begin
        active  <= 1'b0;
        bias_ph <= 1'b0;
      end else if (kx == conv_size - 1) begin
        kx <= '0;
        if (ky == conv_size - 1) begin
          ky <= '0;
          if (ic == total_in - 1) begin
            bias_ph <= 1'b1;
          end else begin
            ic <= ic + 8'd1;
          end
        end else begin
          ky <= ky + 8'd1;
        end
      end else begin
        kx <= kx + 8'd1;
      end
    end
  end

  // image position of the tap, padding reads a harmless address
  always_comb begin
    iy = int'(pix_y) + int'(ky) - int'(conv_pad);
    ix = int'(pix_x) + int'(kx) - int'(conv_pad);
    pad_now = iy < 0 || ix < 0 || iy >= int'(img_size) || ix >= int'(img_size);
    if (pad_now || bias_ph) begin
      img_raddr = in_base;
    end else begin
      img_raddr = iw'(int'(in_base) + int'(ic) * int'(img_size) * int'(img_size)
                      + iy * int'(img_size) + ix);
    end
  end

  // weight block is laid out in beat order
  assign net_raddr = net_base + woff;

  // flags follow the memory read latency
  always_ff @(posedge clk) begin
    if (!xrst) begin
      tap_valid <= 1'b0;
      tap_pad   <= 1'b0;
      tap_first <= 1'b0;
      tap_bias  <= 1'b0;
    end else begin
      tap_valid <= active;
      tap_pad   <= active && !bias_ph && pad_now;
      tap_first <= active && woff == '0;
      tap_bias  <= active && bias_ph;
    end
  end

endmodule

// ==== hw/cnn_mac.sv ====
module cnn_mac (
  input                         clk,
  input                         xrst,
  input  cnn_pkg::data_t        pixel,
  input  cnn_pkg::weight_t      weight,
  input                         tap_valid,
  input                         tap_pad,
  input                         tap_first,
  input                         tap_bias,
  input                         bias_en,
  input                         relu_en,
  output cnn_pkg::data_t        result,
  output logic                  res_valid
);

  localparam cnn_pkg::acc_t sat_hi = (1 <<< ($bits(cnn_pkg::data_t) - 1)) - 1;
  localparam cnn_pkg::acc_t sat_lo = -sat_hi - 1;

  cnn_pkg::acc_t acc;
  cnn_pkg::acc_t prod;
  cnn_pkg::acc_t sum;
  cnn_pkg::acc_t sat;

  // padding taps contribute nothing
  assign prod = tap_pad ? '0 : cnn_pkg::acc_t'(pixel) * cnn_pkg::acc_t'(weight);

  always_comb begin
    sum = acc + (bias_en ? cnn_pkg::acc_t'(weight) : '0);
    if (sum > sat_hi) begin
      sat = sat_hi;
    end else if (sum < sat_lo) begin
      sat = sat_lo;
    end else begin
      sat = sum;
    end
  end

  always_ff @(posedge clk) begin
    if (tap_valid && !tap_bias) begin
      acc <= (tap_first ? '0 : acc) + prod;
    end
    if (tap_valid && tap_bias) begin
      // relu after saturation
      result <= (relu_en && sat < 0) ? '0 : cnn_pkg::data_t'(sat);
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= tap_valid && tap_bias;
    end
  end

endmodule

// ==== hw/cnn_out_serial.sv ====
module cnn_out_serial #(
  parameter int n_core = 2,
  parameter int img_depth = 1024,
  localparam int iw = $clog2(img_depth),
  localparam int cw = (n_core > 1) ? $clog2(n_core) : 1
) (
  input                                   clk,
  input                                   xrst,
  input                                   res_valid,
  input  cnn_pkg::data_t [n_core-1:0]     results,
  input                  [iw-1:0]         out_base,
  input  cnn_pkg::len_t                   pix_ch0,
  input  cnn_pkg::len_t                   fea_size,
  input  cnn_pkg::len_t                   pix_x,
  input  cnn_pkg::len_t                   pix_y,
  input  cnn_pkg::len_t                   total_out,
  output logic                            ser_we,
  output logic           [iw-1:0]         ser_addr,
  output cnn_pkg::data_t                  ser_wdata,
  output logic                            ser_done
);

  cnn_pkg::data_t [n_core-1:0] res_q;
  logic                        active;
  logic [cw-1:0]               idx;
  int                          ch;

  always_ff @(posedge clk) begin
    if (res_valid) begin
      res_q <= results;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      active <= 1'b0;
      idx    <= '0;
    end else if (res_valid) begin
      active <= 1'b1;
      idx    <= '0;
    end else if (active) begin
      idx <= idx + 1'b1;
      if (idx == cw'(n_core - 1)) begin
        active <= 1'b0;
      end
    end
  end

  // channels past total_out in the last group are skipped
  assign ch        = int'(pix_ch0) + int'(idx);
  assign ser_we    = active && ch < int'(total_out);
  assign ser_addr  = iw'(int'(out_base) + ch * int'(fea_size) * int'(fea_size)
                         + int'(pix_y) * int'(fea_size) + int'(pix_x));
  assign ser_wdata = res_q[idx];
  assign ser_done  = active && idx == cw'(n_core - 1);

endmodule

// ==== hw/cnn_top.sv ====
module cnn_top #(
  parameter int n_core = 2,
  parameter int img_depth = 1024,
  parameter int net_depth = 256,
  localparam int iw = $clog2(img_depth),
  localparam int nw = $clog2(net_depth),
  localparam int sw = (n_core > 1) ? $clog2(n_core) : 1
) (
  input                          clk,
  input                          xrst,
  input                          img_we,
  input              [iw-1:0]    img_addr,
  input  cnn_pkg::data_t         img_wdata,
  output cnn_pkg::data_t         img_rdata,
  input                          net_we,
  input              [sw-1:0]    net_sel,
  input              [nw-1:0]    net_addr,
  input  cnn_pkg::weight_t       net_wdata,
  input              [iw-1:0]    in_offset,
  input              [iw-1:0]    out_offset,
  input  cnn_pkg::len_t          total_in,
  input  cnn_pkg::len_t          total_out,
  input  cnn_pkg::len_t          img_size,
  input  cnn_pkg::len_t          conv_size,
  input  cnn_pkg::len_t          conv_pad,
  input                          bias_en,
  input                          relu_en,
  input                          req,
  output logic                   busy,
  output logic                   done,
  output cnn_pkg::core_state_t   core_state
);

  logic                        pix_start;
  cnn_pkg::len_t               pix_x;
  cnn_pkg::len_t               pix_y;
  cnn_pkg::len_t               fea_size;
  cnn_pkg::len_t               pix_ch0;
  logic [nw-1:0]               net_base;
  logic [iw-1:0]               in_base;
  logic [iw-1:0]               out_base;
  logic [iw-1:0]               fetch_raddr;
  logic [nw-1:0]               net_raddr;
  logic                        ser_we;
  logic [iw-1:0]               ser_addr;
  cnn_pkg::data_t              ser_wdata;
  logic                        ser_done;
  logic                        mem_we;
  logic [iw-1:0]               mem_waddr;
  cnn_pkg::data_t              mem_wdata;
  logic [iw-1:0]               mem_raddr;
  logic [n_core-1:0]           net_core_we;
  logic                        bias_en_q;
  logic                        relu_en_q;
  logic                        tap_valid;
  logic                        tap_pad;
  logic                        tap_first;
  logic                        tap_bias;
  cnn_pkg::weight_t            net_rdata [n_core];
  cnn_pkg::data_t [n_core-1:0] mac_res;
  logic [n_core-1:0]           mac_valid;

  // ==========================================================================
  // control
  // ==========================================================================

  cnn_ctrl_core #(
    .n_core(n_core), .img_depth(img_depth), .net_depth(net_depth)
  ) ctrl0 (
    .clk, .xrst, .req, .busy, .done, .core_state,
    .in_offset, .out_offset, .total_in, .total_out, .img_size, .conv_size,
    .conv_pad, .bias_en, .relu_en, .img_we, .img_addr, .img_wdata,
    .net_we, .net_sel, .pix_start, .pix_x, .pix_y, .fea_size, .net_base,
    .in_base, .out_base, .pix_ch0, .fetch_raddr, .ser_we, .ser_addr,
    .ser_wdata, .ser_done, .mem_we, .mem_waddr, .mem_wdata, .mem_raddr,
    .net_core_we, .bias_en_q, .relu_en_q
  );

  cnn_tap_fetch #(.img_depth(img_depth), .net_depth(net_depth)) fetch0 (
    .clk, .xrst, .pix_start, .pix_x, .pix_y, .total_in, .img_size,
    .conv_size, .conv_pad, .in_base, .net_base, .img_raddr(fetch_raddr),
    .net_raddr, .tap_valid, .tap_pad, .tap_first, .tap_bias
  );

  // ==========================================================================
  // datapath
  // ==========================================================================

  cnn_mem #(.word_t(cnn_pkg::data_t), .depth(img_depth)) img_mem0 (
    .clk, .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
    .raddr(mem_raddr), .rdata(img_rdata)
  );

  for (genvar i = 0; i < n_core; i++) begin : g_core
    cnn_mem #(.word_t(cnn_pkg::weight_t), .depth(net_depth)) net_mem (
      .clk, .we(net_core_we[i]), .waddr(net_addr), .wdata(net_wdata),
      .raddr(net_raddr), .rdata(net_rdata[i])
    );

    cnn_mac mac (
      .clk, .xrst, .pixel(img_rdata), .weight(net_rdata[i]), .tap_valid,
      .tap_pad, .tap_first, .tap_bias, .bias_en(bias_en_q),
      .relu_en(relu_en_q), .result(mac_res[i]), .res_valid(mac_valid[i])
    );
  end

  // serializer starts once every core holds its result
  cnn_out_serial #(.n_core(n_core), .img_depth(img_depth)) serial0 (
    .clk, .xrst, .res_valid(&mac_valid), .results(mac_res), .out_base,
    .pix_ch0, .fea_size, .pix_x, .pix_y, .total_out, .ser_we, .ser_addr,
    .ser_wdata, .ser_done
  );

endmodule

// ==== tests/cnn_tb.sv ====
module cnn_tb;

  localparam int n_core = 2;
  localparam int img_depth = 1024;
  localparam int net_depth = 256;
  localparam int iw = $clog2(img_depth);
  localparam int nw = $clog2(net_depth);
  localparam int sw = 1;
  localparam int period = 8;

  logic                 clk;
  logic                 xrst;
  logic                 img_we;
  logic [iw-1:0]        img_addr;
  cnn_pkg::data_t       img_wdata;
  cnn_pkg::data_t       img_rdata;
  logic                 net_we;
  logic [sw-1:0]        net_sel;
  logic [nw-1:0]        net_addr;
  cnn_pkg::weight_t     net_wdata;
  logic [iw-1:0]        in_offset;
  logic [iw-1:0]        out_offset;
  cnn_pkg::len_t        total_in;
  cnn_pkg::len_t        total_out;
  cnn_pkg::len_t        img_size;
  cnn_pkg::len_t        conv_size;
  cnn_pkg::len_t        conv_pad;
  logic                 bias_en;
  logic                 relu_en;
  logic                 req;
  logic                 busy;
  logic                 done;
  cnn_pkg::core_state_t core_state;

  // reference copies of both memories
  cnn_pkg::data_t   img_ref [img_depth];
  cnn_pkg::weight_t net_ref [n_core][net_depth];

  // layer settings as the model sees them
  int c_ti;
  int c_to;
  int c_isz;
  int c_k;
  int c_pad;
  int c_in;
  int c_out;
  bit c_bias;
  bit c_relu;

  int mismatches = 0;
  int failures = 0;
  int done_count = 0;

  cnn_top #(.n_core(n_core), .img_depth(img_depth), .net_depth(net_depth)) dut0 (
    .clk, .xrst, .img_we, .img_addr, .img_wdata, .img_rdata, .net_we, .net_sel,
    .net_addr, .net_wdata, .in_offset, .out_offset, .total_in, .total_out,
    .img_size, .conv_size, .conv_pad, .bias_en, .relu_en, .req, .busy, .done,
    .core_state
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (xrst && done) begin
      done_count <= done_count + 1;
    end
  end

  // ==========================================================================
  // reference model
  // ==========================================================================

  function automatic int group_count(int to);
    return (to + n_core - 1) / n_core;
  endfunction

  // every pixel walks its taps and bias, then the writes
  function automatic int conv_cycles(int ti, int to, int isz, int k, int pad);
    int fea;
    fea = isz + 2 * pad - k + 1;
    return group_count(to) * fea * fea * (ti * k * k + n_core + 4);
  endfunction

  function automatic int load_cycles(int ti, int to, int isz, int k, int pad);
    int fea;
    fea = isz + 2 * pad - k + 1;
    return ti * isz * isz + n_core * group_count(to) * (ti * k * k + 1)
           + 3 * to * fea * fea + 16;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  function automatic cnn_pkg::data_t model_out(int oc, int py, int px);
    int     taps;
    int     c;
    int     base;
    int     iy;
    int     ix;
    longint sum;
    taps = c_ti * c_k * c_k;
    c    = oc % n_core;
    base = (oc / n_core) * (taps + 1);
    sum  = 0;
    for (int ic = 0; ic < c_ti; ic++) begin
      for (int ky = 0; ky < c_k; ky++) begin
        for (int kx = 0; kx < c_k; kx++) begin
          iy = py + ky - c_pad;
          ix = px + kx - c_pad;
          // taps in the padding add nothing
          if (iy >= 0 && ix >= 0 && iy < c_isz && ix < c_isz) begin
            sum += longint'(img_ref[c_in + (ic * c_isz + iy) * c_isz + ix])
                   * longint'(net_ref[c][base + (ic * c_k + ky) * c_k + kx]);
          end
        end
      end
    end
    if (c_bias) begin
      sum += longint'(net_ref[c][base + taps]);
    end
    if (sum > 32767) begin
      sum = 32767;
    end else if (sum < -32768) begin
      sum = -32768;
    end
    if (c_relu && sum < 0) begin
      sum = 0;
    end
    return cnn_pkg::data_t'(sum);
  endfunction

  task automatic compare_data(string name, cnn_pkg::data_t exp, cnn_pkg::data_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic compare_state(string name, cnn_pkg::core_state_t exp,
                               cnn_pkg::core_state_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name());
      mismatches++;
    end
  endtask

  // ==========================================================================
  // host port drivers
  // ==========================================================================

  task automatic write_img(int addr, cnn_pkg::data_t data);
    @(posedge clk);
    img_we    <= 1'b1;
    net_we    <= 1'b0;
    img_addr  <= iw'(addr);
    img_wdata <= data;
    img_ref[addr] = data;
  endtask

  task automatic write_net(int core, int addr, cnn_pkg::weight_t data);
    @(posedge clk);
    img_we    <= 1'b0;
    net_we    <= 1'b1;
    net_sel   <= sw'(core);
    net_addr  <= nw'(addr);
    net_wdata <= data;
    net_ref[core][addr] = data;
  endtask

  // read data shows up one cycle after the address
  task automatic read_img(int addr, output cnn_pkg::data_t data);
    @(posedge clk);
    img_we   <= 1'b0;
    net_we   <= 1'b0;
    img_addr <= iw'(addr);
    @(posedge clk);
    @(negedge clk);
    data = img_rdata;
  endtask

  task automatic set_layer(int ti, int to, int isz, int k, int pad, int in_off,
                           int out_off, bit b, bit r);
    c_ti   = ti;
    c_to   = to;
    c_isz  = isz;
    c_k    = k;
    c_pad  = pad;
    c_in   = in_off;
    c_out  = out_off;
    c_bias = b;
    c_relu = r;
    @(posedge clk);
    total_in   <= cnn_pkg::len_t'(ti);
    total_out  <= cnn_pkg::len_t'(to);
    img_size   <= cnn_pkg::len_t'(isz);
    conv_size  <= cnn_pkg::len_t'(k);
    conv_pad   <= cnn_pkg::len_t'(pad);
    in_offset  <= iw'(in_off);
    out_offset <= iw'(out_off);
    bias_en    <= b;
    relu_en    <= r;
  endtask

  task automatic load_pixels(int pmin, int pmax);
    for (int i = 0; i < c_ti * c_isz * c_isz; i++) begin
      write_img(c_in + i, cnn_pkg::data_t'(rand_range(pmin, pmax)));
    end
  endtask

  // one block per group, bias in the last word
  task automatic load_weights(int core, int wmin, int wmax);
    int blk;
    blk = c_ti * c_k * c_k + 1;
    for (int i = 0; i < group_count(c_to) * blk; i++) begin
      write_net(core, i, cnn_pkg::weight_t'(rand_range(wmin, wmax)));
    end
  endtask

  task automatic run_layer(string name, bit second_req);
    int limit;
    int waited;
    int base;
    limit  = 2 * conv_cycles(c_ti, c_to, c_isz, c_k, c_pad) + 16;
    waited = 0;
    base   = done_count;
    @(posedge clk);
    img_we <= 1'b0;
    net_we <= 1'b0;
    req    <= 1'b1;
    @(posedge clk);
    req <= 1'b0;
    if (second_req) begin
      repeat (5) @(negedge clk);
      if (!busy) begin
        $display("%s: busy is low while the layer runs", name);
        failures++;
      end
      @(posedge clk);
      req <= 1'b1;
      @(posedge clk);
      req <= 1'b0;
    end
    while (done_count == base && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (done_count == base) begin
      $display("%s: done never arrived within %0d cycles", name, limit);
      failures++;
    end else begin
      // a second layer would pulse done again
      repeat (second_req ? limit : 4) @(negedge clk);
      if (done_count - base != 1) begin
        $display("%s: done pulsed %0d times instead of once", name, done_count - base);
        failures++;
      end
    end
  endtask

  task automatic check_outputs(string name);
    cnn_pkg::data_t got;
    int             fea;
    fea = c_isz + 2 * c_pad - c_k + 1;
    for (int oc = 0; oc < c_to; oc++) begin
      for (int py = 0; py < fea; py++) begin
        for (int px = 0; px < fea; px++) begin
          read_img(c_out + (oc * fea + py) * fea + px, got);
          compare_data($sformatf("%s oc%0d y%0d x%0d", name, oc, py, px),
                       model_out(oc, py, px), got);
        end
      end
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic test_host_port();
    cnn_pkg::data_t got;
    int             addr [16];
    compare_state("reset state", cnn_pkg::st_idle, core_state);
    if (busy !== 1'b0 || done !== 1'b0) begin
      $display("busy or done is not low after reset");
      failures++;
    end
    for (int i = 0; i < 16; i++) begin
      addr[i] = i * 64 + rand_range(0, 63);
      write_img(addr[i], cnn_pkg::data_t'(rand_range(-32768, 32767)));
    end
    for (int i = 0; i < 16; i++) begin
      read_img(addr[i], got);
      compare_data($sformatf("host port word %0d", addr[i]), img_ref[addr[i]], got);
    end
  endtask

  task automatic test_basic_conv();
    set_layer(1, 2, 6, 3, 0, 0, 100, 1'b0, 1'b0);
    load_pixels(-100, 100);
    load_weights(0, -20, 20);
    load_weights(1, -20, 20);
    run_layer("basic conv", 1'b0);
    check_outputs("basic conv");
  endtask

  task automatic test_pad_bias();
    set_layer(2, 2, 5, 3, 1, 0, 200, 1'b1, 1'b0);
    load_pixels(-100, 100);
    load_weights(0, -20, 20);
    load_weights(1, -20, 20);
    run_layer("pad bias", 1'b0);
    check_outputs("pad bias");
  endtask

  // core 0 runs far positive, core 1 far negative
  task automatic test_saturation();
    set_layer(2, 2, 4, 3, 0, 0, 100, 1'b0, 1'b0);
    load_pixels(20000, 32767);
    load_weights(0, 64, 127);
    load_weights(1, -128, -64);
    run_layer("saturate", 1'b0);
    check_outputs("saturate");
    set_layer(2, 2, 4, 3, 0, 0, 100, 1'b0, 1'b1);
    run_layer("saturate relu", 1'b0);
    check_outputs("saturate relu");
  endtask

  task automatic test_partial_group();
    cnn_pkg::data_t got;
    set_layer(1, 3, 4, 2, 0, 0, 100, 1'b1, 1'b0);
    load_pixels(-100, 100);
    load_weights(0, -20, 20);
    load_weights(1, -20, 20);
    // first word where a fourth channel would go
    write_img(100 + 3 * 9, cnn_pkg::data_t'(16'h5a5a));
    run_layer("partial group", 1'b0);
    check_outputs("partial group");
    read_img(100 + 3 * 9, got);
    compare_data("partial group sentinel", img_ref[100 + 3 * 9], got);
  endtask

  task automatic test_busy_req();
    set_layer(1, 2, 4, 3, 1, 0, 100, 1'b1, 1'b1);
    load_pixels(-100, 100);
    load_weights(0, -20, 20);
    load_weights(1, -20, 20);
    run_layer("busy req", 1'b1);
    @(negedge clk);
    compare_state("busy req final state", cnn_pkg::st_idle, core_state);
    check_outputs("busy req");
  endtask

  initial begin
    int limit;
    limit = 2 * (conv_cycles(1, 2, 6, 3, 0) + conv_cycles(2, 2, 5, 3, 1)
                 + 2 * conv_cycles(2, 2, 4, 3, 0) + conv_cycles(1, 3, 4, 2, 0)
                 + 2 * conv_cycles(1, 2, 4, 3, 1));
    limit += load_cycles(1, 2, 6, 3, 0) + load_cycles(2, 2, 5, 3, 1)
             + 2 * load_cycles(2, 2, 4, 3, 0) + load_cycles(1, 3, 4, 2, 0)
             + load_cycles(1, 2, 4, 3, 1) + 200;
    #(limit * period);
    $display("watchdog expired after %0d cycles, the run is stuck", limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int seed;
    seed = 99892;
    void'($urandom(seed));
    xrst       = 1'b0;
    img_we     = 1'b0;
    img_addr   = '0;
    img_wdata  = '0;
    net_we     = 1'b0;
    net_sel    = '0;
    net_addr   = '0;
    net_wdata  = '0;
    in_offset  = '0;
    out_offset = '0;
    total_in   = '0;
    total_out  = '0;
    img_size   = '0;
    conv_size  = '0;
    conv_pad   = '0;
    bias_en    = 1'b0;
    relu_en    = 1'b0;
    req        = 1'b0;
    repeat (2) @(posedge clk);
    xrst <= 1'b1;
    @(negedge clk);
    test_host_port();
    test_basic_conv();
    test_pad_bias();
    test_saturation();
    test_partial_group();
    test_busy_req();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/cnn_pkg.sv
hw/cnn_mem.sv
hw/cnn_ctrl_core.sv
hw/cnn_tap_fetch.sv
hw/cnn_mac.sv
hw/cnn_out_serial.sv
hw/cnn_top.sv
tests/cnn_tb.sv

// ==== Makefile ====
# convolution engine, Verilator flow

all: run

run:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module cnn_tb -o cnn_tb
	out=$$(./obj_dir/cnn_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module cnn_top

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
